/* dv/id_trace.txt */
# inputs: fs_valid pc inst es_allowin wb_wen wb_waddr wb_wdata es_rd ms_rd ws_rd
# expected: allowin es_valid rd imm ctrl rs1_data rs2_data br_taken br_target (hex)
0 0 00000000 1 1 1 5 0 0 0  1 0 0 0 0000 0 0 0 0
0 0 00000000 1 1 2 fffffffffffffff0 0 0 0  1 0 0 0 0000 0 0 0 0
0 0 00000000 1 1 3 5 0 0 0  1 0 0 0 0000 0 0 0 0
0 0 00000000 1 1 4 2000 0 0 0  1 0 0 0 0000 0 0 0 0
1 1000 00008333 1 1 0 dead 0 0 0  1 0 0 0 0000 0 0 0 0
1 1004 fff10393 1 0 0 0 0 0 0  1 1 6 0 0040 5 0 0 0
1 1008 0031941b 1 0 0 0 0 0 0  1 1 7 ffffffffffffffff 2040 fffffffffffffff0 0 0 0
1 100c 403084bb 1 0 0 0 0 0 0  1 1 8 3 3140 5 0 0 0
1 1010 80000537 1 0 0 0 0 0 0  1 1 9 0 10c0 5 5 0 0
1 1014 00001597 1 0 0 0 0 0 0  1 1 a ffffffff80000000 2540 0 0 0 0
1 1018 ff822603 1 0 0 0 0 0 0  1 1 b 1000 a040 0 0 0 0
1 101c 0020b823 1 0 0 0 0 0 0  1 1 c fffffffffffffff8 2064 2000 0 0 0
1 1020 0000007f 1 0 0 0 0 0 0  1 1 0 10 2016 5 fffffffffffffff0 0 0
1 1024 002086b3 1 0 0 0 0 0 0  1 1 0 0 0001 0 0 0 0
1 1028 8000e713 1 0 0 0 2 0 0  0 0 0 0 0000 0 0 0 0
1 1028 8000e713 1 0 0 0 0 1 0  0 0 0 0 0000 0 0 0 0
1 1028 8000e713 1 0 0 0 0 0 5  1 1 d 0 0040 5 fffffffffffffff0 0 0
1 102c 00308863 0 0 0 0 0 0 0  0 1 e fffffffffffff800 2440 5 0 0 0
1 102c 00308863 0 0 0 0 0 0 0  0 1 e fffffffffffff800 2440 5 0 0 0
1 102c 00308863 1 0 0 0 0 0 0  1 1 e fffffffffffff800 2440 5 0 0 0
1 1030 00000013 1 0 0 0 0 0 0  1 1 0 10 0000 5 5 1 103c
1 103c 00309463 1 0 0 0 0 0 0  1 0 0 0 0000 0 0 0 0
1 1040 fc1140e3 1 0 0 0 0 0 0  1 1 0 8 0000 5 5 0 1044
1 1044 00000013 1 0 0 0 0 0 0  1 1 0 ffffffffffffffc0 0000 fffffffffffffff0 5 1 1000
1 1000 00116463 1 0 0 0 0 0 0  1 0 0 0 0000 0 0 0 0
1 1004 00115463 1 0 0 0 0 0 0  1 1 0 8 0000 fffffffffffffff0 5 0 1008
1 1008 00117263 1 0 0 0 0 0 0  1 1 0 8 0000 fffffffffffffff0 5 0 100c
1 100c 100002ef 1 0 0 0 0 0 0  1 1 0 4 0000 fffffffffffffff0 5 0 100c
1 1010 00000013 1 0 0 0 0 0 0  1 1 5 100 c040 0 0 1 110c
1 110c 00720367 1 0 0 0 0 0 0  1 0 0 0 0000 0 0 0 0
1 1110 00000013 1 0 0 0 0 0 0  1 1 6 7 c040 2000 0 1 2006
0 0 00000000 1 0 0 0 0 0 0  1 0 0 0 0000 0 0 0 0

/* include/tb_id_checks.svh */
// compare tasks for the decode stage testbench, typed to the shared bus structs
`ifndef TB_ID_CHECKS_SVH
`define TB_ID_CHECKS_SVH

  // first mismatch ends the run
  task automatic report_mismatch(string name, string exp_s, string act_s);
    $display("** Error %s: expected %s, actual %s", name, exp_s, act_s);
    $display("TB FAILED");
    $fatal(1, "mismatch in %s", name);
  endtask

  task automatic check_ctrl(string name, ctrl_t exp, ctrl_t act);
    if (act !== exp) begin
      report_mismatch(name, $sformatf("%p", exp), $sformatf("%p", act));
    end
  endtask

  task automatic check_data(string name, xlen_t exp, xlen_t act);
    if (act !== exp) begin
      report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
    end
  endtask

  task automatic check_br(string name, br_bus_t exp, br_bus_t act);
    if (act.taken !== exp.taken) begin
      report_mismatch({name, " taken"}, $sformatf("%b", exp.taken),
                      $sformatf("%b", act.taken));
    end
    if (act.sel !== exp.sel) begin
      report_mismatch({name, " sel"}, $sformatf("%b", exp.sel),
                      $sformatf("%b", act.sel));
    end
    // target only matters for a resolved branch or jump
    if (exp.sel && act.target !== exp.target) begin
      report_mismatch({name, " target"}, $sformatf("%h", exp.target),
                      $sformatf("%h", act.target));
    end
  endtask

  task automatic check_flow(string name, logic exp_allowin, logic exp_es_valid,
                            logic act_allowin, logic act_es_valid);
    if ({act_allowin, act_es_valid} !== {exp_allowin, exp_es_valid}) begin
      report_mismatch(name,
                      $sformatf("allowin=%b es_valid=%b", exp_allowin, exp_es_valid),
                      $sformatf("allowin=%b es_valid=%b", act_allowin, act_es_valid));
    end
  endtask

`endif

/* dv/tb_id_stage.sv */
// testbench for the instruction decode stage, trace driven checks of decode, hazards and redirect
`timescale 1ns/100ps

module tb_id_stage import rv_id_pkg::*; ();

  localparam int    NUM_RECORDS  = 32;
  localparam int    NUM_FIELDS   = 19;
  localparam int    CLK_PERIOD   = 100;
  localparam int    DRIVE_DELAY  = 10;
  localparam int    SAMPLE_DELAY = 90;   // just before the next edge
  localparam int    RESET_CYCLES = 2;
  localparam int    WATCHDOG_NS  = (RESET_CYCLES + NUM_RECORDS + 20) * CLK_PERIOD;
  localparam string TRACE_FILE   = "dv/id_trace.txt";

  typedef struct packed {
    logic         fs_valid;
    fs_to_ds_t    fs_bus;
    logic         es_allowin;
    wb_to_rf_t    wb;
    inflight_rd_t inflight;
  } stim_t;

  typedef struct packed {
    logic     allowin;
    logic     es_valid;
    gpr_idx_t rd;
    xlen_t    imm;
    ctrl_t    ctrl;
    xlen_t    rs1_data;
    xlen_t    rs2_data;
    br_bus_t  br;
  } expect_t;

  logic         clk;
  logic         rst_n;
  logic         fs_valid;
  fs_to_ds_t    fs_bus;
  logic         ds_allowin;
  logic         es_valid;
  ds_to_es_t    es_bus;
  logic         es_allowin;
  br_bus_t      br;
  wb_to_rf_t    wb;
  inflight_rd_t inflight;
  pc_t          exp_pc;   // pc of the last instruction taken from fetch

  stim_t   stim_q[$];
  expect_t exp_q[$];

  `include "tb_id_checks.svh"

  id_stage #(
    .NUM_GPRS (32)
  ) id_stage_inst (
    .i_clk        (clk),
    .i_rst_n      (rst_n),
    .i_fs_valid   (fs_valid),
    .i_fs_bus     (fs_bus),
    .o_ds_allowin (ds_allowin),
    .o_es_valid   (es_valid),
    .o_es_bus     (es_bus),
    .i_es_allowin (es_allowin),
    .o_br         (br),
    .i_wb         (wb),
    .i_inflight   (inflight)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // one record per non comment line, all fields hex
  task automatic load_trace();
    int          fd;
    int          n;
    string       line;
    logic [63:0] v [NUM_FIELDS];
    stim_t       s;
    expect_t     e;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      $display("could not open the trace file %s", TRACE_FILE);
      $display("TB FAILED");
      $fatal(1, "trace file missing");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
                  v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18]);
      if (n != NUM_FIELDS) begin
        $display("trace record %0d has %0d fields instead of %0d", stim_q.size(), n,
                 NUM_FIELDS);
        $display("TB FAILED");
        $fatal(1, "malformed trace record");
      end
      s.fs_valid       = v[0][0];
      s.fs_bus.pc      = v[1];
      s.fs_bus.inst    = v[2][31:0];
      s.es_allowin     = v[3][0];
      s.wb.wen         = v[4][0];
      s.wb.waddr       = v[5][4:0];
      s.wb.wdata       = v[6];
      s.inflight.es_rd = v[7][4:0];
      s.inflight.ms_rd = v[8][4:0];
      s.inflight.ws_rd = v[9][4:0];
      e.allowin        = v[10][0];
      e.es_valid       = v[11][0];
      e.rd             = v[12][4:0];
      e.imm            = v[13];
      e.ctrl           = ctrl_t'(v[14][$bits(ctrl_t)-1:0]);
      e.rs1_data       = v[15];
      e.rs2_data       = v[16];
      e.br.taken       = v[17][0];
      // a target equal to the fetch pc is a resolved jump held off the redirect
      e.br.sel         = v[17][0] | (v[11][0] & (v[18] == v[1]));
      e.br.target      = v[18];
      stim_q.push_back(s);
      exp_q.push_back(e);
    end
    $fclose(fd);
  endtask

  task automatic drive_inputs(stim_t s);
    fs_valid   = s.fs_valid;
    fs_bus     = s.fs_bus;
    es_allowin = s.es_allowin;
    wb         = s.wb;
    inflight   = s.inflight;
  endtask

  task automatic check_outputs(int idx, expect_t e);
    string tag;
    tag = $sformatf("record %0d", idx);
    check_flow({tag, " flow"}, e.allowin, e.es_valid, ds_allowin, es_valid);
    check_br({tag, " redirect"}, e.br, br);
    // bus contents only mean something while es_valid is high
    if (e.es_valid) begin
      check_data({tag, " rd"}, xlen_t'(e.rd), xlen_t'(es_bus.rd));
      check_data({tag, " pc"}, exp_pc, es_bus.pc);
      check_data({tag, " imm"}, e.imm, es_bus.imm);
      check_data({tag, " rs1 data"}, e.rs1_data, es_bus.rs1_data);
      check_data({tag, " rs2 data"}, e.rs2_data, es_bus.rs2_data);
      check_ctrl({tag, " ctrl"}, e.ctrl, es_bus.ctrl);
    end
  endtask

  initial begin
    rst_n      = 1'b0;
    fs_valid   = 1'b0;
    fs_bus     = '0;
    es_allowin = 1'b1;
    wb         = '0;
    inflight   = '0;
    exp_pc     = '0;
    load_trace();
    if (stim_q.size() < NUM_RECORDS) begin
      $display("trace ran out after %0d of %0d records", stim_q.size(), NUM_RECORDS);
      $display("TB FAILED");
      $fatal(1, "short trace");
    end else begin
      repeat (RESET_CYCLES) @(posedge clk);
      #(DRIVE_DELAY);
      rst_n = 1'b1;
      for (int i = 0; i < NUM_RECORDS; i++) begin
        drive_inputs(stim_q[i]);
        #(SAMPLE_DELAY - DRIVE_DELAY);
        check_outputs(i, exp_q[i]);
        if (stim_q[i].fs_valid && exp_q[i].allowin) begin
          exp_pc = stim_q[i].fs_bus.pc;  // taken in at the coming edge
        end
        @(posedge clk);
        #(DRIVE_DELAY);
      end
      $display("TB PASSED");
      $finish;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns before the trace was finished", WATCHDOG_NS);
    $display("TB FAILED");
    $fatal(1, "timeout");
  end

endmodule

/* hw/branch_unit.sv */
// branch and jump resolution, condition check and target address
`timescale 1ns/100ps

module branch_unit import rv_id_pkg::*; (
  input  logic     i_valid,
  input  pc_t      i_pc,
  input  xlen_t    i_imm,
  input  xlen_t    i_rs1data,
  input  xlen_t    i_rs2data,
  input  logic     i_bren,
  input  br_func_e i_brfunc,
  output logic     o_br_sel,
  output pc_t      o_br_target
);

  logic  eq;
  logic  lt_s;
  logic  lt_u;
  logic  cond;
  xlen_t jalr_sum;

  assign eq   = (i_rs1data == i_rs2data);
  assign lt_s = ($signed(i_rs1data) < $signed(i_rs2data));
  assign lt_u = (i_rs1data < i_rs2data);

  always_comb begin
    case (i_brfunc)
      br_beq:  cond = eq;
      br_bne:  cond = ~eq;
      br_blt:  cond = lt_s;
      br_bge:  cond = ~lt_s;
      br_bltu: cond = lt_u;
      br_bgeu: cond = ~lt_u;
      default: cond = 1'b1;  // jal, jalr
    endcase
  end

  assign jalr_sum    = i_rs1data + i_imm;
  assign o_br_target = (i_brfunc == br_jalr) ? {jalr_sum[63:1], 1'b0} : i_pc + i_imm;
  assign o_br_sel    = i_valid & i_bren & cond;

endmodule

/* hw/gpr_file.sv */
// general register file with two async read ports and one write port, x0 reads zero
`timescale 1ns/100ps

module gpr_file import rv_id_pkg::*; #(
  parameter int NUM_GPRS = 32
) (
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  gpr_idx_t  i_raddr1,
  input  gpr_idx_t  i_raddr2,
  output xlen_t     o_rdata1,
  output xlen_t     o_rdata2,
  input  wb_to_rf_t i_wb
);

  xlen_t regs [NUM_GPRS];
  logic  rd1_ok;
  logic  rd2_ok;
  logic  wr_ok;

  assign rd1_ok = (i_raddr1 != '0) && (i_raddr1 < NUM_GPRS);
  assign rd2_ok = (i_raddr2 != '0) && (i_raddr2 < NUM_GPRS);
  assign wr_ok  = i_wb.wen && (i_wb.waddr != '0) && (i_wb.waddr < NUM_GPRS);

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < NUM_GPRS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ok) begin
      regs[i_wb.waddr] <= i_wb.wdata;
    end
  end

  // no bypass of a same cycle write
  assign o_rdata1 = rd1_ok ? regs[i_raddr1] : '0;
  assign o_rdata2 = rd2_ok ? regs[i_raddr2] : '0;

endmodule

/* hw/id_issue_ctrl.sv */
// decode stage flow control, holds the fetched instruction and checks source hazards
`timescale 1ns/100ps

module id_issue_ctrl import rv_id_pkg::*; (
  input  logic         i_clk,
  input  logic         i_rst_n,
  input  logic         i_fs_valid,
  input  fs_to_ds_t    i_fs_bus,
  output logic         o_ds_allowin,
  input  logic         i_es_allowin,
  output logic         o_es_valid,
  input  inflight_rd_t i_inflight,
  input  gpr_idx_t     i_rs1,
  input  gpr_idx_t     i_rs2,
  input  logic         i_br_sel,
  input  pc_t          i_br_target,
  output inst_t        o_inst,
  output pc_t          o_pc,
  output br_bus_t      o_br
);

  logic      ds_valid;
  fs_to_ds_t ds_bus;
  logic      hazard;
  logic      ready_go;
  logic      br_taken;

  // a nonzero pending rd matching either source
  function automatic logic rd_hit(gpr_idx_t rd, gpr_idx_t rs1, gpr_idx_t rs2);
    return (rd != '0) && ((rd == rs1) || (rd == rs2));
  endfunction

  assign hazard = rd_hit(i_inflight.es_rd, i_rs1, i_rs2)
               || rd_hit(i_inflight.ms_rd, i_rs1, i_rs2)
               || rd_hit(i_inflight.ws_rd, i_rs1, i_rs2);

  assign ready_go     = ~hazard;
  assign o_ds_allowin = ~ds_valid | (ready_go & i_es_allowin);
  assign o_es_valid   = ds_valid & ready_go;

  // no redirect when fetch is already on the target
  assign br_taken = i_br_sel & ready_go & (i_br_target != i_fs_bus.pc);
  assign o_br     = '{taken: br_taken, sel: i_br_sel, target: i_br_target};

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_valid & ~br_taken; // squash wrong path
    end
  end

  // cleared at reset so an idle stage decodes to nothing
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ds_bus <= '0;
    end else if (i_fs_valid && o_ds_allowin) begin
      ds_bus <= i_fs_bus;
    end
  end

  assign o_inst = ds_bus.inst;
  assign o_pc   = ds_bus.pc;

endmodule

/* hw/id_stage.sv */
// instruction decode stage top, issue control with decoder, register file and branch unit
`timescale 1ns/100ps

module id_stage import rv_id_pkg::*; #(
  parameter int NUM_GPRS = 32
) (
  input  logic         i_clk,
  input  logic         i_rst_n,
  // from fetch
  input  logic         i_fs_valid,
  input  fs_to_ds_t    i_fs_bus,
  output logic         o_ds_allowin,
  // to execute
  output logic         o_es_valid,
  output ds_to_es_t    o_es_bus,
  input  logic         i_es_allowin,
  // redirect to fetch
  output br_bus_t      o_br,
  // write back and pending destinations
  input  wb_to_rf_t    i_wb,
  input  inflight_rd_t i_inflight
);

  inst_t    ds_inst;
  pc_t      ds_pc;
  gpr_idx_t rs1;
  gpr_idx_t rs2;
  gpr_idx_t rd;
  xlen_t    imm;
  xlen_t    rs1_data;
  xlen_t    rs2_data;
  ctrl_t    ctrl;
  logic     bren;
  br_func_e brfunc;
  logic     br_sel;
  pc_t      br_target;

  id_issue_ctrl u_issue (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_fs_valid   (i_fs_valid),
    .i_fs_bus     (i_fs_bus),
    .o_ds_allowin (o_ds_allowin),
    .i_es_allowin (i_es_allowin),
    .o_es_valid   (o_es_valid),
    .i_inflight   (i_inflight),
    .i_rs1        (rs1),
    .i_rs2        (rs2),
    .i_br_sel     (br_sel),
    .i_br_target  (br_target),
    .o_inst       (ds_inst),
    .o_pc         (ds_pc),
    .o_br         (o_br)
  );

  inst_decoder u_dec (
    .i_inst   (ds_inst),
    .o_rs1    (rs1),
    .o_rs2    (rs2),
    .o_rd     (rd),
    .o_imm    (imm),
    .o_ctrl   (ctrl),
    .o_bren   (bren),
    .o_brfunc (brfunc)
  );

  gpr_file #(
    .NUM_GPRS (NUM_GPRS)
  ) u_gprs (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .o_rdata1 (rs1_data),
    .o_rdata2 (rs2_data),
    .i_wb     (i_wb)
  );

  branch_unit u_bru (
    .i_valid     (o_es_valid),
    .i_pc        (ds_pc),
    .i_imm       (imm),
    .i_rs1data   (rs1_data),
    .i_rs2data   (rs2_data),
    .i_bren      (bren),
    .i_brfunc    (brfunc),
    .o_br_sel    (br_sel),
    .o_br_target (br_target)
  );

  assign o_es_bus = '{rs1_data: rs1_data, rs2_data: rs2_data, imm: imm,
                      pc: ds_pc, rd: rd, ctrl: ctrl};

endmodule

/* hw/inst_decoder.sv */
// rv64i base integer decoder producing register indices, immediate and control
`timescale 1ns/100ps

module inst_decoder import rv_id_pkg::*; (
  input  inst_t    i_inst,
  output gpr_idx_t o_rs1,
  output gpr_idx_t o_rs2,
  output gpr_idx_t o_rd,
  output xlen_t    o_imm,
  output ctrl_t    o_ctrl,
  output logic     o_bren,
  output br_func_e o_brfunc
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t      imm_i, imm_s, imm_b, imm_u, imm_j;
  ctrl_t      ctrl;
  logic       legal;
  logic       use_rs1;
  logic       use_rs2;

  // funct3 to alu op, alt picks sub or sra
  function automatic alu_op_e alu_from_f3(logic [2:0] f3, logic alt);
    case (f3)
      3'b000:  return alt ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return alt ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  assign opcode = opcode_e'(i_inst[6:0]);
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    ctrl     = '0;
    legal    = 1'b0;
    use_rs1  = 1'b0;
    use_rs2  = 1'b0;
    o_bren   = 1'b0;
    o_brfunc = br_beq;
    o_imm    = '0;
    case (opcode)
      opc_op_imm, opc_op_imm_32: begin
        use_rs1           = 1'b1;
        o_imm             = imm_i;
        ctrl.alu_src2_sel = SRC2_IMM;
        ctrl.word_cut     = (opcode == opc_op_imm_32);
        ctrl.gpr_wen      = 1'b1;
        ctrl.alu_op       = alu_from_f3(funct3, (funct3 == 3'b101) & i_inst[30]);
        if (opcode == opc_op_imm) begin
          // rv64 shamt is 6 bits wide
          legal = (funct3 == 3'b001) ? (i_inst[31:26] == 6'b000000) :
                  (funct3 == 3'b101) ? ({i_inst[31], i_inst[29:26]} == 5'b0) : 1'b1;
        end else begin
          legal = (funct3 == 3'b000) ||
                  (funct3 == 3'b001 && funct7 == 7'b0000000) ||
                  (funct3 == 3'b101 && {funct7[6], funct7[4:0]} == 6'b0);
        end
      end
      opc_op, opc_op_32: begin
        use_rs1       = 1'b1;
        use_rs2       = 1'b1;
        ctrl.word_cut = (opcode == opc_op_32);
        ctrl.gpr_wen  = 1'b1;
        ctrl.alu_op   = alu_from_f3(funct3, funct7[5]);
        if (funct7 == 7'b0100000) begin
          legal = (funct3 == 3'b000) || (funct3 == 3'b101);
        end else if (funct7 == 7'b0000000) begin
          legal = (opcode == opc_op) || (funct3 inside {3'b000, 3'b001, 3'b101});
        end
      end
      opc_lui: begin
        legal = 1'b1;
        o_imm = imm_u;
        ctrl.alu_src2_sel = SRC2_IMM;
        ctrl.alu_op       = alu_pass_b;
        ctrl.gpr_wen      = 1'b1;
      end
      opc_auipc: begin
        legal = 1'b1;
        o_imm = imm_u;
        ctrl.alu_src1_sel = SRC1_PC;
        ctrl.alu_src2_sel = SRC2_IMM;
        ctrl.gpr_wen      = 1'b1;
      end
      opc_load: begin
        legal   = (funct3 != 3'b111);
        use_rs1 = 1'b1;
        o_imm   = imm_i;
        ctrl.alu_src2_sel = SRC2_IMM;
        ctrl.gpr_wen      = 1'b1;
        ctrl.mem_ren      = 1'b1;
        ctrl.mem_op       = mem_op_e'(funct3);
      end
      opc_store: begin
        legal   = (funct3[2] == 1'b0);
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        o_imm   = imm_s;
        ctrl.alu_src2_sel = SRC2_IMM;
        ctrl.mem_wen      = 1'b1;
        ctrl.mem_op       = mem_op_e'(funct3);
      end
      opc_branch: begin
        legal    = (funct3[2:1] != 2'b01);
        use_rs1  = 1'b1;
        use_rs2  = 1'b1;
        o_imm    = imm_b;
        o_bren   = 1'b1;
        o_brfunc = br_func_e'(funct3);
      end
      opc_jal, opc_jalr: begin
        legal    = (opcode == opc_jal) || (funct3 == 3'b000);
        use_rs1  = (opcode == opc_jalr);
        o_imm    = (opcode == opc_jal) ? imm_j : imm_i;
        o_bren   = 1'b1;
        o_brfunc = (opcode == opc_jal) ? br_jal : br_jalr;
        ctrl.alu_src1_sel = SRC1_PC;   // link value pc + 4
        ctrl.alu_src2_sel = SRC2_FOUR;
        ctrl.gpr_wen      = 1'b1;
      end
      default: ;
    endcase
    if (!legal) begin
      ctrl         = '0;
      ctrl.invalid = 1'b1;
      use_rs1      = 1'b0;
      use_rs2      = 1'b0;
      o_bren       = 1'b0;
    end
  end

  // unused fields read as x0 so they never match a pending write
  assign o_rs1  = use_rs1 ? i_inst[19:15] : '0;
  assign o_rs2  = use_rs2 ? i_inst[24:20] : '0;
  assign o_rd   = ctrl.gpr_wen ? i_inst[11:7] : '0;
  assign o_ctrl = ctrl;

endmodule

/* hw/rv_id_pkg.sv */
// rv64i decode stage shared widths, opcodes and bus structs
package rv_id_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [63:0] pc_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  gpr_idx_t;

  typedef enum logic [6:0] {
    opc_load       = 7'b0000011,
    opc_op_imm     = 7'b0010011,
    opc_auipc      = 7'b0010111,
    opc_op_imm_32  = 7'b0011011,
    opc_store      = 7'b0100011,
    opc_op         = 7'b0110011,
    opc_lui        = 7'b0110111,
    opc_op_32      = 7'b0111011,
    opc_branch     = 7'b1100011,
    opc_jalr       = 7'b1100111,
    opc_jal        = 7'b1101111
  } opcode_e;

  typedef enum logic [4:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } alu_op_e;

  // branch codes follow funct3, jumps fill the unused slots
  typedef enum logic [2:0] {
    br_beq = 3'b000, br_bne = 3'b001, br_jal = 3'b010, br_jalr = 3'b011,
    br_blt = 3'b100, br_bge = 3'b101, br_bltu = 3'b110, br_bgeu = 3'b111
  } br_func_e;

  // load/store size and sign, same as funct3
  typedef enum logic [2:0] {
    mem_b = 3'b000, mem_h = 3'b001, mem_w = 3'b010, mem_d = 3'b011,
    mem_bu = 3'b100, mem_hu = 3'b101, mem_wu = 3'b110
  } mem_op_e;

  localparam logic       SRC1_RS1  = 1'b0;
  localparam logic       SRC1_PC   = 1'b1;
  localparam logic [1:0] SRC2_RS2  = 2'd0;
  localparam logic [1:0] SRC2_IMM  = 2'd1;
  localparam logic [1:0] SRC2_FOUR = 2'd2;

  typedef struct packed {
    logic       alu_src1_sel;
    logic [1:0] alu_src2_sel;
    logic       word_cut;     // 32-bit w form
    alu_op_e    alu_op;
    logic       gpr_wen;
    logic       mem_ren;
    logic       mem_wen;
    mem_op_e    mem_op;
    logic       invalid;
  } ctrl_t;

  typedef struct packed {
    inst_t inst;
    pc_t   pc;
  } fs_to_ds_t;

  typedef struct packed {
    xlen_t    rs1_data;
    xlen_t    rs2_data;
    xlen_t    imm;
    pc_t      pc;
    gpr_idx_t rd;
    ctrl_t    ctrl;
  } ds_to_es_t;

  typedef struct packed {
    logic taken;
    logic sel;
    pc_t  target;
  } br_bus_t;

  typedef struct packed {
    logic     wen;
    gpr_idx_t waddr;
    xlen_t    wdata;
  } wb_to_rf_t;

  // zero index means no pending write in that stage
  typedef struct packed {
    gpr_idx_t es_rd;
    gpr_idx_t ms_rd;
    gpr_idx_t ws_rd;
  } inflight_rd_t;

endpackage

/* project.f */
+incdir+include
hw/rv_id_pkg.sv
hw/gpr_file.sv
hw/branch_unit.sv
hw/inst_decoder.sv
hw/id_issue_ctrl.sv
hw/id_stage.sv
dv/tb_id_stage.sv
